// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
		--top-module rs_div_tb -Mdir obj_dir -o rs_div_sim
	./obj_dir/rs_div_sim | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== common/rs_pkg.sv ====
package rs_pkg;

    localparam int RS_ENTRIES = 8;
    localparam int RS_IDX_W   = 3;
    localparam int TAG_W      = 8;
    localparam int DATA_W     = 32;
    localparam int PC_W       = 32;
    localparam int OP_W       = 4;

    // lower index wins when two buses carry the same tag
    localparam int BUS_ALU   = 0;
    localparam int BUS_MUL   = 1;
    localparam int BUS_DIV   = 2;
    localparam int BUS_LOAD  = 3;
    localparam int NUM_BUSES = BUS_LOAD + 1;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
        logic              valid;
    } operand_t;

    typedef struct packed {
        logic [PC_W-1:0]  pc;
        logic [TAG_W-1:0] rd;
        logic [OP_W-1:0]  op;
        operand_t         src1;
        operand_t         src2;
    } dispatch_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } result_bus_t;

    typedef struct packed {
        logic [PC_W-1:0]   pc;
        logic [TAG_W-1:0]  rd;
        logic [OP_W-1:0]   op;
        logic [DATA_W-1:0] src1_data;
        logic [DATA_W-1:0] src2_data;
    } issue_t;

    // first set bit of req at or after start, in ring order
    function automatic logic ring_pick(
        input  logic [RS_ENTRIES-1:0] req,
        input  logic [RS_IDX_W-1:0]   start,
        output logic [RS_IDX_W-1:0]   pick
    );
        logic                found;
        logic [RS_IDX_W-1:0] idx;
        found = 1'b0;
        pick  = start;
        for (int i = 0; i < RS_ENTRIES; i++) begin
            idx = start + i[RS_IDX_W-1:0]; // wraps around the ring
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
        return found;
    endfunction

    // fill a waiting operand from the buses
    function automatic operand_t snoop_operand(
        input operand_t    opnd,
        input result_bus_t buses [NUM_BUSES]
    );
        operand_t res;
        res = opnd;
        for (int b = BUS_LOAD; b >= BUS_ALU; b--) begin // last hit is lowest index
            if (!opnd.valid && buses[b].valid && buses[b].tag == opnd.tag) begin
                res.valid = 1'b1;
                res.data  = buses[b].data;
            end
        end
        return res;
    endfunction

endpackage

// ==== rs_div/rs_dispatch.sv ====
`timescale 1ns/1ps

module rs_dispatch (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          dispatch_valid,
    input  rs_pkg::dispatch_t             dispatch,
    input  rs_pkg::result_bus_t           result_buses [rs_pkg::NUM_BUSES],
    input  logic [rs_pkg::RS_ENTRIES-1:0] busy,
    output logic [rs_pkg::RS_ENTRIES-1:0] alloc,
    output rs_pkg::dispatch_t             alloc_entry,
    output logic                          rs_full
);

    logic [rs_pkg::RS_IDX_W-1:0] tail;
    logic [rs_pkg::RS_IDX_W-1:0] free_idx;
    logic                        free_found;

    // search from tail so a live entry is never overwritten
    always_comb begin
        free_found = rs_pkg::ring_pick(~busy, tail, free_idx);
        alloc      = '0;
        if (dispatch_valid && free_found) begin
            alloc[free_idx] = 1'b1;
        end
    end

    assign rs_full = &busy;

    // same-cycle bypass from the result buses
    always_comb begin
        alloc_entry      = dispatch;
        alloc_entry.src1 = rs_pkg::snoop_operand(dispatch.src1, result_buses);
        alloc_entry.src2 = rs_pkg::snoop_operand(dispatch.src2, result_buses);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tail <= '0;
        end else if (dispatch_valid && free_found) begin
            tail <= free_idx + 1'b1; // one past the new entry
        end
    end

endmodule

// ==== rs_div/rs_div_top.sv ====
`timescale 1ns/1ps

module rs_div_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                dispatch_valid,
    input  rs_pkg::dispatch_t   dispatch,
    input  rs_pkg::result_bus_t result_buses [rs_pkg::NUM_BUSES],
    output logic                rs_full,
    output logic                issue_valid,
    output rs_pkg::issue_t      issue
);

    logic [rs_pkg::RS_ENTRIES-1:0] busy;
    logic [rs_pkg::RS_ENTRIES-1:0] ready;
    logic [rs_pkg::RS_ENTRIES-1:0] alloc;
    logic [rs_pkg::RS_ENTRIES-1:0] grant;
    rs_pkg::dispatch_t             alloc_entry;
    rs_pkg::issue_t                entry_out [rs_pkg::RS_ENTRIES];

    rs_dispatch u_dispatch (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .result_buses   (result_buses),
        .busy           (busy),
        .alloc          (alloc),
        .alloc_entry    (alloc_entry),
        .rs_full        (rs_full)
    );

    generate
        for (genvar i = 0; i < rs_pkg::RS_ENTRIES; i++) begin : g_entry
            rs_entry u_entry (
                .clk          (clk),
                .reset        (reset),
                .alloc        (alloc[i]),
                .alloc_entry  (alloc_entry),
                .result_buses (result_buses),
                .grant        (grant[i]),
                .busy         (busy[i]),
                .ready        (ready[i]),
                .entry_out    (entry_out[i])
            );
        end
    endgenerate

    rs_issue_select u_select (
        .clk         (clk),
        .reset       (reset),
        .ready       (ready),
        .entries     (entry_out),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

// ==== rs_div/rs_entry.sv ====
`timescale 1ns/1ps

module rs_entry (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  rs_pkg::dispatch_t   alloc_entry,
    input  rs_pkg::result_bus_t result_buses [rs_pkg::NUM_BUSES],
    input  logic                grant,
    output logic                busy,
    output logic                ready,
    output rs_pkg::issue_t      entry_out
);

    logic [rs_pkg::PC_W-1:0]  pc;
    logic [rs_pkg::TAG_W-1:0] rd;
    logic [rs_pkg::OP_W-1:0]  op;
    rs_pkg::operand_t         src1;
    rs_pkg::operand_t         src2;

    // alloc and grant never hit the same entry in one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (alloc) begin
            busy <= 1'b1;
        end else if (grant) begin
            busy <= 1'b0; // freed at issue
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pc   <= alloc_entry.pc;
            rd   <= alloc_entry.rd;
            op   <= alloc_entry.op;
            src1 <= alloc_entry.src1;
            src2 <= alloc_entry.src2;
        end else begin
            src1 <= rs_pkg::snoop_operand(src1, result_buses); // wakeup
            src2 <= rs_pkg::snoop_operand(src2, result_buses);
        end
    end

    assign ready = busy && src1.valid && src2.valid;

    always_comb begin
        entry_out.pc        = pc;
        entry_out.rd        = rd;
        entry_out.op        = op;
        entry_out.src1_data = src1.data;
        entry_out.src2_data = src2.data;
    end

endmodule

// ==== rs_div/rs_issue_select.sv ====
`timescale 1ns/1ps

module rs_issue_select (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rs_pkg::RS_ENTRIES-1:0] ready,
    input  rs_pkg::issue_t                entries [rs_pkg::RS_ENTRIES],
    output logic [rs_pkg::RS_ENTRIES-1:0] grant,
    output logic                          issue_valid,
    output rs_pkg::issue_t                issue
);

    logic [rs_pkg::RS_IDX_W-1:0] head;
    logic [rs_pkg::RS_IDX_W-1:0] pick;
    logic                        pick_found;

    // rotating priority with head first
    always_comb begin
        pick_found = rs_pkg::ring_pick(ready, head, pick);
        grant      = '0;
        if (pick_found) begin
            grant[pick] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head        <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= pick_found;
            if (pick_found) begin
                head <= pick + 1'b1; // skip past the issued entry
            end
        end
    end

    // granted entry goes to the divider
    always_ff @(posedge clk) begin
        if (pick_found) begin
            issue <= entries[pick];
        end
    end

endmodule

// ==== verification/rs_div_checker.sv ====
`timescale 1ns/1ps

module rs_div_checker (
    input  logic           clk,
    input  logic           reset,
    input  logic           rs_full,
    input  logic           issue_valid,
    input  rs_pkg::issue_t issue,
    input  logic           exp_full,
    input  logic           exp_issue_valid,
    input  rs_pkg::issue_t exp_issue,
    output int             error_count,
    output int             issue_count
);

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            $display("FAIL time %0t %s expected %h got %h", $time, name, exp, got);
            error_count++;
        end
    endtask

    // registered outputs settle well before the falling edge
    always @(negedge clk) begin
        if (reset) begin
            error_count = 0;
            issue_count = 0;
        end else begin
            compare("rs_full", 32'(exp_full), 32'(rs_full));
            compare("issue_valid", 32'(exp_issue_valid), 32'(issue_valid));
            if (issue_valid && exp_issue_valid) begin
                compare("issue.pc", exp_issue.pc, issue.pc);
                compare("issue.rd", 32'(exp_issue.rd), 32'(issue.rd));
                compare("issue.op", 32'(exp_issue.op), 32'(issue.op));
                compare("issue.src1_data", exp_issue.src1_data, issue.src1_data);
                compare("issue.src2_data", exp_issue.src2_data, issue.src2_data);
            end
            if (issue_valid) begin
                issue_count++;
            end
        end
    end

endmodule

// ==== verification/rs_div_tb.sv ====
`timescale 1ns/1ps

module rs_div_tb;

    logic                          clk;
    logic                          reset;
    logic                          dispatch_valid;
    rs_pkg::dispatch_t             dispatch;
    rs_pkg::result_bus_t           buses [rs_pkg::NUM_BUSES];
    logic                          rs_full;
    logic                          issue_valid;
    rs_pkg::issue_t                issue;

    // reference model state
    logic [rs_pkg::RS_ENTRIES-1:0] m_busy;
    rs_pkg::dispatch_t             m_ent [rs_pkg::RS_ENTRIES];
    logic [rs_pkg::RS_IDX_W-1:0]   m_head;
    logic [rs_pkg::RS_IDX_W-1:0]   m_tail;
    logic                          m_issue_valid;
    rs_pkg::issue_t                m_issue;
    logic                          m_full;

    logic [31:0]                   rng;
    int                            n_dispatched;
    int                            other_errors;
    int                            chk_errors;
    int                            chk_issues;

    rs_div_top DUT (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .result_buses   (buses),
        .rs_full        (rs_full),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    rs_div_checker u_checker (
        .clk             (clk),
        .reset           (reset),
        .rs_full         (rs_full),
        .issue_valid     (issue_valid),
        .issue           (issue),
        .exp_full        (m_full),
        .exp_issue_valid (m_issue_valid),
        .exp_issue       (m_issue),
        .error_count     (chk_errors),
        .issue_count     (chk_issues)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign m_full = &m_busy;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng = xorshift(rng);
        r   = rng;
    endtask

    // first set bit at or after start or -1 when none
    function automatic int ring_first(input logic [rs_pkg::RS_ENTRIES-1:0] req,
                                      input logic [rs_pkg::RS_IDX_W-1:0] start);
        logic [rs_pkg::RS_IDX_W-1:0] idx;
        idx = start;
        for (int i = 0; i < rs_pkg::RS_ENTRIES; i++) begin
            if (req[idx]) begin
                return int'(idx);
            end
            idx = idx + 1'b1;
        end
        return -1;
    endfunction

    function automatic rs_pkg::operand_t wake_operand(input rs_pkg::operand_t o,
            input rs_pkg::result_bus_t b [rs_pkg::NUM_BUSES]);
        rs_pkg::operand_t r;
        r = o;
        for (int i = 0; i < rs_pkg::NUM_BUSES; i++) begin
            if (!r.valid && b[i].valid && b[i].tag == o.tag) begin
                r.valid = 1'b1; // lowest bus found first
                r.data  = b[i].data;
            end
        end
        return r;
    endfunction

    always @(posedge clk or posedge reset) begin : model
        logic [rs_pkg::RS_ENTRIES-1:0] ready_v;
        int g;
        int a;
        if (reset) begin
            m_busy        = '0;
            m_head        = '0;
            m_tail        = '0;
            m_issue_valid = 1'b0;
        end else begin
            for (int i = 0; i < rs_pkg::RS_ENTRIES; i++) begin
                ready_v[i] = m_busy[i] && m_ent[i].src1.valid && m_ent[i].src2.valid;
            end
            g = ring_first(ready_v, m_head);
            a = dispatch_valid ? ring_first(~m_busy, m_tail) : -1; // before the grant frees
            m_issue_valid = (g >= 0);
            if (g >= 0) begin
                m_issue.pc        = m_ent[g[2:0]].pc;
                m_issue.rd        = m_ent[g[2:0]].rd;
                m_issue.op        = m_ent[g[2:0]].op;
                m_issue.src1_data = m_ent[g[2:0]].src1.data;
                m_issue.src2_data = m_ent[g[2:0]].src2.data;
                m_busy[g[2:0]]    = 1'b0;
                m_head            = 3'(g + 1);
            end
            for (int i = 0; i < rs_pkg::RS_ENTRIES; i++) begin
                m_ent[i].src1 = wake_operand(m_ent[i].src1, buses);
                m_ent[i].src2 = wake_operand(m_ent[i].src2, buses);
            end
            if (a >= 0) begin
                m_ent[a[2:0]]      = dispatch;
                m_ent[a[2:0]].src1 = wake_operand(dispatch.src1, buses); // bypass
                m_ent[a[2:0]].src2 = wake_operand(dispatch.src2, buses);
                m_busy[a[2:0]]     = 1'b1;
                m_tail             = 3'(a + 1);
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        dispatch_valid = 1'b0;
        for (int b = 0; b < rs_pkg::NUM_BUSES; b++) begin
            buses[b].valid = 1'b0;
        end
    endtask

    task automatic set_bus(input int b, input logic [7:0] tag, input logic [31:0] data);
        buses[b].valid = 1'b1;
        buses[b].tag   = tag;
        buses[b].data  = data;
    endtask

    task automatic put_dispatch(input logic [7:0] t1, input logic v1,
                                input logic [7:0] t2, input logic v2);
        logic [31:0] r;
        next_rand(r);
        dispatch.pc = r;
        next_rand(r);
        dispatch.src1 = '{tag: t1, data: r, valid: v1};
        next_rand(r);
        dispatch.src2 = '{tag: t2, data: r, valid: v2};
        next_rand(r);
        dispatch.rd    = r[7:0];
        dispatch.op    = r[11:8];
        dispatch_valid = 1'b1;
        n_dispatched++;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        next_rand(r);
        put_dispatch({5'd0, r[2:0]}, r[3], {5'd0, r[6:4]}, r[7]); // tags 0 to 7
        n_dispatched--;
        dispatch_valid = !rs_full && (r[9:8] != 2'b00);
        if (dispatch_valid) begin
            n_dispatched++;
        end
        for (int b = 0; b < rs_pkg::NUM_BUSES; b++) begin
            next_rand(r);
            buses[b].valid = r[0];
            buses[b].tag   = {5'd0, r[3:1]};
            next_rand(r);
            buses[b].data  = r;
        end
    endtask

    // flush sweeps all random tags on the ALU bus
    task automatic wait_idle(input int limit, input logic flush);
        int cycles;
        cycles = 0;
        while ((m_busy != '0 || m_issue_valid || issue_valid) && cycles < limit) begin
            if (flush) begin
                set_bus(rs_pkg::BUS_ALU, 8'(cycles % 8), 32'(cycles));
            end
            step();
            cycles++;
        end
        idle_inputs();
        if (m_busy != '0 || m_issue_valid || issue_valid) begin
            $display("timeout: station still busy after %0d cycles", limit);
            other_errors++;
        end
    endtask

    initial begin
        rng            = 32'hca60;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        for (int b = 0; b < rs_pkg::NUM_BUSES; b++) begin
            buses[b] = '0;
        end
        n_dispatched = 0;
        other_errors = 0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        repeat (4) step();

        put_dispatch(8'd20, 1'b1, 8'd21, 1'b1); // both operands at hand
        step();
        idle_inputs();
        wait_idle(20, 1'b0);

        put_dispatch(8'd12, 1'b0, 8'd13, 1'b0);
        set_bus(rs_pkg::BUS_MUL, 8'd12, 32'h1111_1111);
        set_bus(rs_pkg::BUS_ALU, 8'd12, 32'h2222_2222);
        step();
        idle_inputs();
        step();
        set_bus(rs_pkg::BUS_LOAD, 8'd13, 32'h4444_4444);
        set_bus(rs_pkg::BUS_DIV, 8'd13, 32'h3333_3333);
        step();
        idle_inputs();
        wait_idle(20, 1'b0);

        for (int i = 0; i < rs_pkg::RS_ENTRIES; i++) begin
            put_dispatch(8'd14, 1'b0, 8'd15, 1'b1);
            step();
        end
        idle_inputs();
        repeat (2) step(); // station full
        set_bus(rs_pkg::BUS_DIV, 8'd14, 32'h5555_aaaa);
        step();
        idle_inputs();
        repeat (2) step();
        put_dispatch(8'd16, 1'b1, 8'd17, 1'b1); // reuses a freed entry
        step();
        idle_inputs();
        wait_idle(40, 1'b0);

        for (int c = 0; c < 3000; c++) begin
            drive_random();
            step();
        end
        idle_inputs();
        wait_idle(200, 1'b1);
        step();

        if (chk_issues != n_dispatched) begin
            $display("%0d instructions dispatched but %0d issued", n_dispatched, chk_issues);
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other failures", chk_errors, other_errors);
        if (chk_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
common/rs_pkg.sv
rs_div/rs_dispatch.sv
rs_div/rs_entry.sv
rs_div/rs_issue_select.sv
rs_div/rs_div_top.sv
verification/rs_div_checker.sv
verification/rs_div_tb.sv
